// File: dv/sketch_checker.sv
/*
 * scoreboard for the sketch register read port
 * expected records arrive in order with each accepted rd_start
 * one read in flight at a time, so each rd_valid pops the queue head
 * final_check closes the run and flags reads that never returned
 */
`timescale 1ns/1ps
`default_nettype none

module sketch_checker
(
    input  logic                   clk,
    input  logic                   memreset,
    input  logic                   rd_start,
    input  logic                   rd_busy,
    input  logic                   rd_valid,
    input  sketch_pkg::sram_rec_t  rd_data,
    input  logic                   exp_push,     // expected record of this cycle's start
    input  logic [7:0]             exp_test,
    input  sketch_pkg::sram_addr_t exp_addr,
    input  sketch_pkg::sram_rec_t  exp_rec,
    input  logic                   busy_probe,   // read must still be pending here
    input  logic                   final_check,
    output int                     err_count,
    output int                     read_count
);

    import sketch_pkg::*;

    typedef struct packed {
        logic [7:0] test;
        sram_addr_t addr;
        sram_rec_t  rec;
    } exp_entry_t;

    exp_entry_t exp_q [$];          // pending reads in accept order
    exp_entry_t head;
    exp_entry_t entry;
    int         n_err      = 0;
    int         n_valid    = 0;     // rd_valid pulses seen
    int         n_accepted = 0;     // starts taken while idle
    logic       in_reset   = 1'b1;

    assign err_count  = n_err;
    assign read_count = n_valid;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "reset_zero";
            8'd2:    return "single_pkt";
            8'd3:    return "overwrite";
            8'd4:    return "random_stream";
            8'd5:    return "read_under_load";
            8'd6:    return "busy_start";
            default: return "unknown";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // sampled on the rising edge before the inputs move
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (memreset)
        begin
            in_reset = 1'b1;
        end
        else
        begin
            if (in_reset)                           // first edge after release
            begin
                in_reset = 1'b0;
                if (rd_busy !== 1'b0 || rd_valid !== 1'b0)
                begin
                    $display("rd_busy or rd_valid is not low after reset");
                    n_err++;
                end
            end
            if (rd_start && !rd_busy)
                n_accepted++;
            if (exp_push)
            begin
                entry.test = exp_test;
                entry.addr = exp_addr;
                entry.rec  = exp_rec;
                exp_q.push_back(entry);
            end
            if (rd_valid)
            begin
                n_valid++;
                if (exp_q.size() == 0)
                begin
                    $display("rd_valid with no accepted read pending, data %h", rd_data);
                    n_err++;
                end
                else
                begin
                    head = exp_q.pop_front();
                    if (rd_data !== head.rec)
                    begin
                        $display("CHECK FAILED %s addr %h: expected %h actual %h",
                                 test_name(head.test), head.addr, head.rec, rd_data);
                        n_err++;
                    end
                end
            end
            if (busy_probe && !rd_busy)
            begin
                $display("read finished before the update stream ended");
                n_err++;
            end
            if (final_check)
            begin
                if (exp_q.size() != 0)
                begin
                    $display("%0d accepted reads never returned rd_valid", exp_q.size());
                    n_err++;
                end
                if (n_valid != n_accepted)
                begin
                    $display("rd_valid count %0d differs from accepted starts %0d",
                             n_valid, n_accepted);
                    n_err++;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_sketch.sv
/*
 * testbench for the flow sketch top
 * inputs change 1 ns after the rising edge, the checker samples on the edge
 * model keeps the last record per address, same as the overwrite ram
 * watchdog length follows the planned packet and read counts
 */
`timescale 1ns/1ps
`default_nettype none

`include "sketch_consts.svh"

module tb_sketch;

    import sketch_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int N_RANDOM_PKT    = 300;
    localparam int N_STREAM_PKT    = 40;
    localparam int N_PKT_PLAN      = N_RANDOM_PKT + N_STREAM_PKT + 8;
    localparam int N_RD_PLAN       = 8 + 1 + 2 + N_RANDOM_PKT + 1 + 2;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_PKT_PLAN + 20 * N_RD_PLAN + 500;

    logic       clk;
    logic       memreset;
    logic       pkt_valid;
    pkt_hdr_t   pkt_hdr;
    logic       rd_start;
    sram_addr_t rd_addr;
    logic       rd_busy;
    logic       rd_valid;
    sram_rec_t  rd_data;
    logic       exp_push;       // to the checker, alongside rd_start
    logic [7:0] exp_test;
    sram_addr_t exp_addr;
    sram_rec_t  exp_rec;
    logic       busy_probe;
    logic       final_check;
    int         err_count;
    int         read_count;

    sram_rec_t  model [sram_addr_t];    // reference sketch contents
    bit         touched [sram_addr_t];  // addresses hit by the random stream

    sketch_top i_sketch_top
    (
        .clk      (clk),
        .memreset (memreset),
        .pkt_valid(pkt_valid),
        .pkt_hdr  (pkt_hdr),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .rd_busy  (rd_busy),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

    sketch_checker i_sketch_checker
    (
        .clk        (clk),
        .memreset   (memreset),
        .rd_start   (rd_start),
        .rd_busy    (rd_busy),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .exp_push   (exp_push),
        .exp_test   (exp_test),
        .exp_addr   (exp_addr),
        .exp_rec    (exp_rec),
        .busy_probe (busy_probe),
        .final_check(final_check),
        .err_count  (err_count),
        .read_count (read_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference hash and model helpers
    //////////////////////////////////////////////////////////////////////
    // xor fold of the key, then top bits of two 32 bit products
    function automatic void ref_hash(input flow_key_t key, output sram_addr_t addr,
                                     output flow_tag_t tag);
        logic [31:0] fold;
        logic [63:0] prod;
        int          s;
        fold = {24'd0, key[`SK_KEY_W-1:96]};
        for (s = 0; s < 3; s++)
            fold = fold ^ key[s*32 +: 32];
        prod = {32'd0, fold} * {32'd0, `SK_HASH_A};
        addr = prod[31:32-`SK_ADDR_W];                 // mod 2^32, top bits
        prod = {32'd0, fold} * {32'd0, `SK_HASH_B};
        tag  = prod[31:32-`SK_TAG_W];
    endfunction

    function automatic flow_key_t rand_key();
        logic [127:0] r;
        r = {$urandom, $urandom, $urandom, $urandom};
        return r[`SK_KEY_W-1:0];
    endfunction

    function automatic byte_cnt_t rand_len();
        return byte_cnt_t'($urandom_range(1500, 64));
    endfunction

    function automatic sram_rec_t model_read(input sram_addr_t addr);
        if (model.exists(addr))
            return model[addr];
        return '0;                                      // never written
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drive tasks, all leave inputs 1 ns after an edge
    //////////////////////////////////////////////////////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic send_packet(input flow_key_t key, input byte_cnt_t len);
        sram_addr_t addr;
        flow_tag_t  tag;
        sram_rec_t  rec;
        ref_hash(key, addr, tag);
        rec.tag     = tag;
        rec.bytes   = len;
        model[addr] = rec;                              // last write wins
        pkt_hdr.key = key;
        pkt_hdr.len = len;
        pkt_valid   = 1'b1;
        step();
        pkt_valid   = 1'b0;                             // back to back calls keep it high
    endtask

    task automatic issue_read(input logic [7:0] test_id, input sram_addr_t addr);
        while (rd_busy)
            step();
        rd_start = 1'b1;
        rd_addr  = addr;
        exp_push = 1'b1;
        exp_test = test_id;
        exp_addr = addr;
        exp_rec  = model_read(addr);
        step();
        rd_start = 1'b0;
        exp_push = 1'b0;
    endtask

    task automatic wait_read_done();
        while (rd_busy)
            step();
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial
    begin
        flow_key_t  key_a;
        flow_key_t  key_b;
        sram_addr_t addr_a;
        sram_addr_t addr_b;
        flow_tag_t  tag_a;
        flow_tag_t  tag_b;
        sram_addr_t a;
        int         i;
        void'($urandom(32'h6f33));
        memreset    = 1'b1;
        pkt_valid   = 1'b0;
        pkt_hdr     = '0;
        rd_start    = 1'b0;
        rd_addr     = '0;
        exp_push    = 1'b0;
        exp_test    = 8'd0;
        exp_addr    = '0;
        exp_rec     = '0;
        busy_probe  = 1'b0;
        final_check = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        memreset = 1'b0;
        idle(2);

        // empty sketch reads zero everywhere
        for (i = 0; i < 8; i++)
        begin
            issue_read(8'd1, sram_addr_t'($urandom));
            wait_read_done();
        end

        // one packet, then its record
        key_a = rand_key();
        ref_hash(key_a, addr_a, tag_a);
        send_packet(key_a, rand_len());
        idle(4);
        issue_read(8'd2, addr_a);
        wait_read_done();

        // same key new length, then an address collision with another tag
        send_packet(key_a, rand_len());
        idle(4);
        issue_read(8'd3, addr_a);
        wait_read_done();
        do
        begin
            key_b = rand_key();
            ref_hash(key_b, addr_b, tag_b);
        end
        while (addr_b != addr_a || tag_b == tag_a);
        send_packet(key_b, rand_len());
        idle(4);
        issue_read(8'd3, addr_a);
        wait_read_done();

        // random stream back to back, then every touched address
        for (i = 0; i < N_RANDOM_PKT; i++)
        begin
            key_b = rand_key();
            ref_hash(key_b, addr_b, tag_b);
            touched[addr_b] = 1'b1;
            send_packet(key_b, rand_len());
        end
        idle(4);
        if (touched.first(a))
        begin
            do
            begin
                issue_read(8'd4, a);
                wait_read_done();
            end
            while (touched.next(a));
        end

        // read parked behind an update stream that avoids its address
        fork
            begin
                for (i = 0; i < N_STREAM_PKT; i++)
                begin
                    do
                    begin
                        key_b = rand_key();
                        ref_hash(key_b, addr_b, tag_b);
                    end
                    while (addr_b == addr_a);
                    send_packet(key_b, rand_len());
                end
                busy_probe = 1'b1;                      // updates still in the pipe
                step();
                busy_probe = 1'b0;
            end
            begin
                idle(10);
                issue_read(8'd5, addr_a);
            end
        join
        wait_read_done();
        idle(4);

        // starts while busy must be dropped
        for (i = 0; i < 2; i++)
        begin
            issue_read(8'd6, sram_addr_t'($urandom));
            repeat (4)
            begin
                rd_start = rd_busy;                     // pulse only while busy
                rd_addr  = sram_addr_t'($urandom);
                step();
            end
            rd_start = 1'b0;
            wait_read_done();
        end

        idle(2);
        final_check = 1'b1;
        step();
        final_check = 1'b0;
        step();
        $display("summary: reads=%0d error_count=%0d", read_count, err_count);
        if (err_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/sketch_consts.svh
/*
 * widths and hash constants for the flow sketch
 * widths are fixed here, modules carry no parameters
 * the address width sets the sketch depth (2**SK_ADDR_W entries)
 * both multipliers must stay odd for the universal hash to spread keys
 */
`ifndef SKETCH_CONSTS_SVH
`define SKETCH_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// field widths
//////////////////////////////////////////////////////////////////////
`define SK_KEY_W    104         // src ip, dst ip, src port, dst port, proto
`define SK_ADDR_W   10          // 1024 sketch entries
`define SK_TAG_W    16          // flow identity kept next to the count
`define SK_BYTES_W  16          // packet length in bytes

//////////////////////////////////////////////////////////////////////
// hash multipliers, odd 32 bit
//////////////////////////////////////////////////////////////////////
`define SK_HASH_A   32'h9e3779b1    // address hash
`define SK_HASH_B   32'h85ebca77    // tag hash

`endif

// File: rtl/flow_hash.sv
/*
 * two stage universal hash, five-tuple to sketch address and flow tag
 * fixed latency of 2 cycles pkt_valid -> upd_valid, accepts a header every cycle
 * no backpressure, every header becomes one write request
 * only bits 103:0 of the key take part in the fold
 */
`timescale 1ns/1ps
`default_nettype none

`include "sketch_consts.svh"

module flow_hash
(
    input  logic                 clk,
    input  logic                 memreset,
    input  logic                 pkt_valid,     // one cycle strobe per header
    input  sketch_pkg::pkt_hdr_t pkt_hdr,
    output logic                 upd_valid,
    output sketch_pkg::sram_req_t upd_req      // always a write
);

    import sketch_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // fold and multiply, combinational ahead of stage 1
    //////////////////////////////////////////////////////////////////////
    logic [31:0] fold;
    logic [31:0] prod_a;
    logic [31:0] prod_b;

    // xor of the 32 bit slices, top byte zero extended
    assign fold = pkt_hdr.key[31:0]
                ^ pkt_hdr.key[63:32]
                ^ pkt_hdr.key[95:64]
                ^ {24'd0, pkt_hdr.key[`SK_KEY_W-1:96]};

    assign prod_a = fold * `SK_HASH_A;     // mod 2^32, upper bits dropped
    assign prod_b = fold * `SK_HASH_B;

    //////////////////////////////////////////////////////////////////////
    // stage 1, products and length
    //////////////////////////////////////////////////////////////////////
    logic        s1_valid;
    logic [31:0] s1_prod_a;
    logic [31:0] s1_prod_b;
    byte_cnt_t   s1_len;

    always_ff @(posedge clk)
    begin
        if (memreset)
            s1_valid <= 1'b0;
        else
            s1_valid <= pkt_valid;
    end

    // payload, follows the valid bit
    always_ff @(posedge clk)
    begin
        s1_prod_a <= prod_a;
        s1_prod_b <= prod_b;
        s1_len    <= pkt_hdr.len;
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2, slice top bits into the write request
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
            upd_valid <= 1'b0;
        else
            upd_valid <= s1_valid;
    end

    always_ff @(posedge clk)
    begin
        upd_req.we          <= 1'b1;                        // updates only write
        upd_req.addr        <= s1_prod_a[31 -: `SK_ADDR_W]; // top bits spread best
        upd_req.wdata.tag   <= s1_prod_b[31 -: `SK_TAG_W];
        upd_req.wdata.bytes <= s1_len;                      // new record replaces old
    end

endmodule

`default_nettype wire

// File: rtl/reg_reader.sv
/*
 * register read port of the sketch
 * one read at a time, rd_start is dropped while rd_busy is high
 * latency varies with update traffic, 3 cycles to rd_valid when idle
 * rd_data holds the last record until the next rd_valid
 */
`timescale 1ns/1ps
`default_nettype none

module reg_reader
(
    input  logic                   clk,
    input  logic                   memreset,
    input  logic                   rd_start,    // strobe
    input  sketch_pkg::sram_addr_t rd_addr,
    input  logic                   rdq_grant,
    input  sketch_pkg::sram_rec_t  mem_rdata,
    output logic                   rdq_valid,
    output sketch_pkg::sram_addr_t rdq_addr,    // latched on accept
    output logic                   rd_busy,
    output logic                   rd_valid,    // one cycle pulse
    output sketch_pkg::sram_rec_t  rd_data
);

    import sketch_pkg::*;

    rd_state_t state;

    assign rd_busy   = (state != RD_IDLE);
    assign rdq_valid = (state == RD_WAIT_GRANT);   // held until the arbiter grants

    //////////////////////////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            state    <= RD_IDLE;
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= 1'b0;
            case (state)
                RD_IDLE:
                begin
                    if (rd_start)
                        state <= RD_WAIT_GRANT;
                end
                RD_WAIT_GRANT:
                begin
                    if (rdq_grant)
                        state <= RD_WAIT_DATA;     // ram read issued this cycle
                end
                RD_WAIT_DATA:
                begin
                    rd_valid <= 1'b1;              // mem_rdata valid now
                    state    <= RD_IDLE;
                end
                default:
                begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // address and data capture
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (state == RD_IDLE && rd_start)
            rdq_addr <= rd_addr;
        if (state == RD_WAIT_DATA)
            rd_data <= mem_rdata;
    end

endmodule

`default_nettype wire

// File: rtl/sketch_pkg.sv
/*
 * shared types for the flow sketch
 * widths come from sketch_consts.svh, the include dir must be on the path
 * sram_rec_t is the stored word, tag in the upper half
 */
`default_nettype none

package sketch_pkg;

`include "sketch_consts.svh"

    //////////////////////////////////////////////////////////////////////
    // plain vectors
    //////////////////////////////////////////////////////////////////////
    typedef logic [`SK_KEY_W-1:0]   flow_key_t;     // five-tuple
    typedef logic [`SK_ADDR_W-1:0]  sram_addr_t;    // sketch entry index
    typedef logic [`SK_TAG_W-1:0]   flow_tag_t;     // hash identity of a flow
    typedef logic [`SK_BYTES_W-1:0] byte_cnt_t;     // packet length

    //////////////////////////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////////////////////////
    // header strobe payload, 120 bits
    typedef struct packed {
        flow_key_t  key;
        byte_cnt_t  len;
    } pkt_hdr_t;

    // one sketch record, 32 bits
    typedef struct packed {
        flow_tag_t  tag;
        byte_cnt_t  bytes;
    } sram_rec_t;

    // single port request, 43 bits
    typedef struct packed {
        logic       we;         // 1 write, 0 read
        sram_addr_t addr;
        sram_rec_t  wdata;      // ignored on reads
    } sram_req_t;

    // register read port fsm
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_GRANT,
        RD_WAIT_DATA
    } rd_state_t;

endpackage

`default_nettype wire

// File: rtl/sketch_sram.sv
/*
 * behavioural single port sketch ram, 1024 x 32
 * one cycle read latency, rdata only changes on a read
 * per entry valid bit, cleared by memreset, so unwritten entries read zero
 */
`timescale 1ns/1ps
`default_nettype none

`include "sketch_consts.svh"

module sketch_sram
(
    input  logic                  clk,
    input  logic                  memreset,
    input  logic                  mem_en,
    input  sketch_pkg::sram_req_t mem_req,
    output sketch_pkg::sram_rec_t mem_rdata
);

    import sketch_pkg::*;

    localparam int DEPTH = 1 << `SK_ADDR_W;

    sram_rec_t        mem [DEPTH];  // record storage
    logic [DEPTH-1:0] ent_valid;    // written since reset

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (memreset)
            ent_valid <= '0;
        else if (mem_en && mem_req.we)
            ent_valid[mem_req.addr] <= 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // array write and registered read
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_req.we)
                mem[mem_req.addr] <= mem_req.wdata;   // overwrite, no accumulate
            else if (ent_valid[mem_req.addr])
                mem_rdata <= mem[mem_req.addr];
            else
                mem_rdata <= '0;                      // never written
        end
    end

endmodule

`default_nettype wire

// File: rtl/sketch_top.sv
/*
 * flow sketch top, hash writer and register reader share one ram
 * single clock, synchronous memreset for every block
 * a read granted one or more cycles after upd_valid sees that record
 */
`timescale 1ns/1ps
`default_nettype none

module sketch_top
(
    input  logic                   clk,
    input  logic                   memreset,
    input  logic                   pkt_valid,
    input  sketch_pkg::pkt_hdr_t   pkt_hdr,
    input  logic                   rd_start,
    input  sketch_pkg::sram_addr_t rd_addr,
    output logic                   rd_busy,
    output logic                   rd_valid,
    output sketch_pkg::sram_rec_t  rd_data
);

    import sketch_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////
    logic       upd_valid;
    sram_req_t  upd_req;        // hash -> arbiter
    logic       rdq_valid;
    sram_addr_t rdq_addr;       // reader -> arbiter
    logic       rdq_grant;
    logic       mem_en;
    sram_req_t  mem_req;        // arbiter -> ram
    sram_rec_t  mem_rdata;      // ram -> reader

    flow_hash i_flow_hash
    (
        .clk       (clk),
        .memreset  (memreset),
        .pkt_valid (pkt_valid),
        .pkt_hdr   (pkt_hdr),
        .upd_valid (upd_valid),
        .upd_req   (upd_req)
    );

    reg_reader i_reg_reader
    (
        .clk       (clk),
        .memreset  (memreset),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr),
        .rdq_grant (rdq_grant),
        .mem_rdata (mem_rdata),
        .rdq_valid (rdq_valid),
        .rdq_addr  (rdq_addr),
        .rd_busy   (rd_busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    sram_arbiter i_sram_arbiter
    (
        .clk       (clk),
        .memreset  (memreset),
        .upd_valid (upd_valid),
        .upd_req   (upd_req),
        .rdq_valid (rdq_valid),
        .rdq_addr  (rdq_addr),
        .rdq_grant (rdq_grant),
        .mem_en    (mem_en),
        .mem_req   (mem_req)
    );

    sketch_sram i_sketch_sram
    (
        .clk       (clk),
        .memreset  (memreset),
        .mem_en    (mem_en),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: rtl/sram_arbiter.sv
/*
 * fixed priority arbiter in front of the single port sketch ram
 * updates are served the cycle they arrive and are never stalled
 * reads get the port only in cycles with no update, so a steady
 * update stream starves the reader until it ends
 * grant and port mux are purely combinational
 */
`timescale 1ns/1ps
`default_nettype none

module sram_arbiter
(
    input  logic                  clk,
    input  logic                  memreset,
    input  logic                  upd_valid,
    input  sketch_pkg::sram_req_t upd_req,
    input  logic                  rdq_valid,    // level held until granted
    input  sketch_pkg::sram_addr_t rdq_addr,
    output logic                  rdq_grant,    // pulse when the read goes out
    output logic                  mem_en,
    output sketch_pkg::sram_req_t mem_req
);

    import sketch_pkg::*;

    // reader drops rdq_valid after its grant, so each request sees one pulse
    assign rdq_grant = rdq_valid & ~upd_valid;
    assign mem_en    = upd_valid | rdq_grant;

    //////////////////////////////////////////////////////////////////////
    // port mux with update priority
    //////////////////////////////////////////////////////////////////////
    always_comb
    begin
        if (upd_valid)
        begin
            mem_req = upd_req;
        end
        else
        begin
            mem_req.we    = 1'b0;       // read
            mem_req.addr  = rdq_addr;
            mem_req.wdata = '0;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the sketch testbench with verilator, run it and check sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f tb.f --top-module tb_sketch \
    && ./obj_dir/Vtb_sketch | tee sim.log \
    && grep -qx "No errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb.f
+incdir+include
rtl/sketch_pkg.sv
rtl/flow_hash.sv
rtl/sram_arbiter.sv
rtl/sketch_sram.sv
rtl/reg_reader.sv
rtl/sketch_top.sv
dv/sketch_checker.sv
dv/tb_sketch.sv
